// ==== sources.f ====
+incdir+testbench
logic/fp_format_pkg.sv
logic/fp_isa_pkg.sv
logic/fp_unpack.sv
logic/fp_decode.sv
logic/fp_execute.sv
logic/fp_pack.sv
logic/rv_fpu.sv
testbench/rv_fpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rv_fpu testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f sources.f --top-module rv_fpu_tb -Mdir obj_dir -o rv_fpu_sim > build.log 2>&1 &&
./obj_dir/rv_fpu_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== testbench/fp_model.svh ====
`ifndef FP_MODEL_SVH
`define FP_MODEL_SVH

// field widths of the RISC-V formats
function automatic int exp_width(logic [1:0] fmt);
	case (fmt)
		fp_format_pkg::H: return fp_format_pkg::H_EXP_LEN;
		fp_format_pkg::S: return fp_format_pkg::S_EXP_LEN;
		default: return fp_format_pkg::D_EXP_LEN;
	endcase
endfunction

function automatic int frac_width(logic [1:0] fmt);
	case (fmt)
		fp_format_pkg::H: return fp_format_pkg::H_FRAC_LEN;
		fp_format_pkg::S: return fp_format_pkg::S_FRAC_LEN;
		default: return fp_format_pkg::D_FRAC_LEN;
	endcase
endfunction

// ones over the bits the format occupies
function automatic logic [63:0] low_mask(logic [1:0] fmt);
	int n;
	n = 1 + exp_width(fmt) + frac_width(fmt);
	if (n >= 64) begin
		return '1;
	end
	return (64'd1 << n) - 64'd1;
endfunction

function automatic logic [63:0] pack_fields(logic [1:0] fmt, logic s, logic [63:0] e,
	logic [63:0] f);
	int fw;
	fw = frac_width(fmt);
	return (64'(s) << (exp_width(fmt) + fw)) | (e << fw) | f;
endfunction

function automatic logic [63:0] exp_field(logic [1:0] fmt, logic [63:0] v);
	return (v >> frac_width(fmt)) & ((64'd1 << exp_width(fmt)) - 64'd1);
endfunction

function automatic logic [63:0] frac_field(logic [1:0] fmt, logic [63:0] v);
	return v & ((64'd1 << frac_width(fmt)) - 64'd1);
endfunction

function automatic logic sign_bit(logic [1:0] fmt, logic [63:0] v);
	return v[exp_width(fmt) + frac_width(fmt)];
endfunction

// one-hot fclass result
function automatic logic [63:0] class_mask(logic [1:0] fmt, logic [63:0] v);
	logic [63:0] e;
	logic [63:0] f;
	logic s;
	int bit_pos;
	e = exp_field(fmt, v);
	f = frac_field(fmt, v);
	s = sign_bit(fmt, v);
	if (e == (64'd1 << exp_width(fmt)) - 64'd1) begin
		if (f == 0) begin
			bit_pos = s ? 0 : 7;
		end else begin
			bit_pos = f[frac_width(fmt) - 1] ? 9 : 8;
		end
	end else if (e == 0) begin
		bit_pos = (f == 0) ? (s ? 3 : 4) : (s ? 2 : 5);
	end else begin
		bit_pos = s ? 1 : 6;
	end
	return 64'd1 << bit_pos;
endfunction

function automatic logic [63:0] inject_sign(logic [1:0] fmt, logic [2:0] rm, logic [63:0] a,
	logic [63:0] b);
	logic s;
	case (rm)
		3'd0: s = sign_bit(fmt, b);
		3'd1: s = !sign_bit(fmt, b);
		default: s = sign_bit(fmt, a) ^ sign_bit(fmt, b);
	endcase
	return pack_fields(fmt, s, exp_field(fmt, a), frac_field(fmt, a));
endfunction

function automatic logic widens(logic [1:0] src, logic [1:0] dst);
	return (dst == fp_format_pkg::S && src == fp_format_pkg::H) ||
		(dst == fp_format_pkg::D && src == fp_format_pkg::H) ||
		(dst == fp_format_pkg::D && src == fp_format_pkg::S);
endfunction

// exact widening conversion, value by value
function automatic logic [63:0] widen(logic [1:0] src, logic [1:0] dst, logic [63:0] v);
	logic [63:0] e;
	logic [63:0] f;
	logic [63:0] dst_max;
	logic s;
	int sfw;
	int dfw;
	int src_bias;
	int dst_bias;
	int lead;
	int new_exp;
	e = exp_field(src, v);
	f = frac_field(src, v);
	s = sign_bit(src, v);
	sfw = frac_width(src);
	dfw = frac_width(dst);
	src_bias = (1 << (exp_width(src) - 1)) - 1;
	dst_bias = (1 << (exp_width(dst) - 1)) - 1;
	dst_max = (64'd1 << exp_width(dst)) - 64'd1;
	if (e == (64'd1 << exp_width(src)) - 64'd1) begin
		// every nan turns into the canonical quiet nan
		if (f != 0) begin
			return pack_fields(dst, 1'b0, dst_max, 64'd1 << (dfw - 1));
		end
		return pack_fields(dst, s, dst_max, 64'd0);
	end
	if (e == 0 && f == 0) begin
		return pack_fields(dst, s, 64'd0, 64'd0);
	end
	if (e == 0) begin
		lead = 0;
		for (int i = 0; i < sfw; i++) begin
			if (f[i]) begin
				lead = i;
			end
		end
		// value is f * 2^(1 - bias - sfw)
		new_exp = lead + 1 - src_bias - sfw + dst_bias;
		return pack_fields(dst, s, 64'(new_exp), (f & ((64'd1 << lead) - 64'd1)) << (dfw - lead));
	end
	new_exp = int'(e) - src_bias + dst_bias;
	return pack_fields(dst, s, 64'(new_exp), f << (dfw - sfw));
endfunction

function automatic fp_isa_pkg::fpu_resp_t predict_response(fp_isa_pkg::fpu_req_t req);
	fp_isa_pkg::fpu_resp_t r;
	logic [1:0] fmt;
	logic [1:0] src;
	logic [63:0] mask;
	logic fmt_ok;
	logic no_fields;
	fmt = req.funct7[1:0];
	src = req.funct5[1:0];
	mask = low_mask(fmt);
	fmt_ok = (fmt != fp_format_pkg::Q);
	no_fields = (req.funct5 == 5'd0);
	r.sigill = 1'b1;
	r.rd = '0;
	if (req.opcode != fp_isa_pkg::OP_FP) begin
		return r;
	end
	case (req.funct7[6:2])
		5'b00100: begin
			if (fmt_ok && req.rm <= 3'd2) begin
				r.sigill = 1'b0;
				r.rd = inject_sign(fmt, req.rm, req.rs1, req.rs2);
			end
		end
		5'b01000: begin
			if (req.funct5[4:2] == 3'b000 && widens(src, fmt)) begin
				r.sigill = 1'b0;
				r.rd = widen(src, fmt, req.rs1);
			end
		end
		5'b11100: begin
			if (fmt_ok && no_fields && req.rm == 3'd0) begin
				r.sigill = 1'b0;
				r.rd = req.rs1 & mask;
				if (req.rs1[exp_width(fmt) + frac_width(fmt)]) begin
					r.rd = r.rd | ~mask;
				end
			end else if (fmt_ok && no_fields && req.rm == 3'd1) begin
				r.sigill = 1'b0;
				r.rd = class_mask(fmt, req.rs1);
			end
		end
		5'b11110: begin
			if (fmt_ok && no_fields && req.rm == 3'd0) begin
				r.sigill = 1'b0;
				r.rd = req.rs1 & mask;
			end
		end
		default: ;
	endcase
	return r;
endfunction

`endif

// ==== testbench/rv_fpu_tb.sv ====
`default_nettype none

`include "fp_model.svh"

module rv_fpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_SIGN = 500;
	localparam int N_CLASS = 500;
	localparam int N_MOVE = 400;
	localparam int N_ILLEGAL = 400;
	localparam int N_MIXED = 600;
	localparam int TOTAL_REQS = N_SIGN + N_CLASS + N_MOVE + N_ILLEGAL + N_MIXED;
	localparam int CYCLE_LIMIT = 3 * TOTAL_REQS + 200;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	fp_isa_pkg::fpu_req_t in;
	logic out_valid;
	logic out_ready;
	fp_isa_pkg::fpu_resp_t out;

	fp_isa_pkg::fpu_resp_t expected_q[$];
	int errors;
	int checks;
	int cycles;
	int stall_pct;

	rv_fpu rv_fpu_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in(in),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out(out)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no finish after %0d cycles, pipeline stuck", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [1:0] random_fmt();
		case ($urandom_range(2))
			0: return fp_format_pkg::H;
			1: return fp_format_pkg::S;
			default: return fp_format_pkg::D;
		endcase
	endfunction

	// weighted value classes, garbage above the format
	function automatic logic [63:0] random_value(logic [1:0] fmt);
		int ew;
		int fw;
		int emax;
		logic [63:0] e;
		logic [63:0] f;
		logic [63:0] value;
		logic s;
		ew = exp_width(fmt);
		fw = frac_width(fmt);
		emax = (1 << ew) - 1;
		s = 1'($urandom_range(1));
		f = {$urandom, $urandom} & ((64'd1 << fw) - 64'd1);
		e = 64'($urandom_range(emax - 1, 1));
		case ($urandom_range(9))
			0: begin
				e = '0;
				f = '0;
			end
			1: begin
				e = '0;
				if (f == 0) begin
					f = 64'd1;
				end
			end
			5: begin
				e = 64'(emax);
				f = '0;
			end
			6: begin
				e = 64'(emax);
				f[fw - 1] = 1'b1;
			end
			7: begin
				e = 64'(emax);
				f[fw - 1] = 1'b0;
				if (f == 0) begin
					f = 64'd1;
				end
			end
			8, 9: return {$urandom, $urandom};
			default: ;
		endcase
		value = pack_fields(fmt, s, e, f);
		if (ew + fw + 1 < 64) begin
			value = value | ({$urandom, $urandom} << (ew + fw + 1));
		end
		return value;
	endfunction

	// kind 0 sgnj, 1 fclass, 2 moves and widening, 3 illegal
	function automatic fp_isa_pkg::fpu_req_t random_req(int kind);
		fp_isa_pkg::fpu_req_t r;
		logic [1:0] fmt;
		logic [1:0] src;
		logic [4:0] op5;
		fmt = random_fmt();
		r.opcode = fp_isa_pkg::OP_FP;
		r.rm = '0;
		r.funct5 = '0;
		r.rs1 = random_value(fmt);
		r.rs2 = random_value(fmt);
		r.rs3 = {$urandom, $urandom};
		case (kind)
			0: begin
				r.funct7 = {5'b00100, fmt};
				r.rm = 3'($urandom_range(2));
			end
			1: begin
				r.funct7 = {5'b11100, fmt};
				r.rm = 3'd1;
			end
			2: begin
				case ($urandom_range(2))
					0: begin
						r.funct7 = {5'b11100, fmt};
					end
					1: begin
						r.funct7 = {5'b11110, fmt};
						r.rs1 = {$urandom, $urandom};
					end
					default: begin
						case ($urandom_range(2))
							0: {fmt, src} = {fp_format_pkg::S, fp_format_pkg::H};
							1: {fmt, src} = {fp_format_pkg::D, fp_format_pkg::H};
							default: {fmt, src} = {fp_format_pkg::D, fp_format_pkg::S};
						endcase
						r.funct7 = {5'b01000, fmt};
						r.funct5 = {3'b000, src};
						r.rm = 3'($urandom);
						r.rs1 = random_value(src);
					end
				endcase
			end
			default: begin
				case ($urandom_range(4))
					0: begin
						r.opcode = 5'($urandom);
						r.funct7 = 7'($urandom);
						r.rm = 3'($urandom);
						r.funct5 = 5'($urandom);
					end
					// Q format on ops that are legal otherwise
					1: begin
						case ($urandom_range(2))
							0: op5 = 5'b00100;
							1: op5 = 5'b11100;
							default: op5 = 5'b11110;
						endcase
						r.funct7 = {op5, fp_format_pkg::Q};
						r.rm = 3'($urandom_range(1));
					end
					2: begin
						case ($urandom_range(2))
							0: {fmt, src} = {fp_format_pkg::H, fp_format_pkg::S};
							1: {fmt, src} = {fp_format_pkg::H, fp_format_pkg::D};
							default: {fmt, src} = {fp_format_pkg::S, fp_format_pkg::D};
						endcase
						r.funct7 = {5'b01000, fmt};
						r.funct5 = {3'b000, src};
					end
					// add, sub, div, sqrt, compare, min/max
					3: begin
						case ($urandom_range(5))
							0: op5 = 5'b00000;
							1: op5 = 5'b00001;
							2: op5 = 5'b00011;
							3: op5 = 5'b01011;
							4: op5 = 5'b10100;
							default: op5 = 5'b00101;
						endcase
						r.funct7 = {op5, fmt};
						r.rm = 3'($urandom);
					end
					default: begin
						r.opcode = {3'b100, 2'($urandom)};
						r.funct7 = 7'($urandom);
						r.rm = 3'($urandom);
					end
				endcase
			end
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic take_result();
		fp_isa_pkg::fpu_resp_t want;
		if (expected_q.size() == 0) begin
			errors++;
			$display("a result came out at %0t with no request outstanding", $time);
		end else begin
			want = expected_q.pop_front();
			check_value("out.sigill", 64'(want.sigill), 64'(out.sigill));
			check_value("out.rd", want.rd, out.rd);
		end
	endtask

	// drive at the falling edge, decide both transfers before the rising one
	task automatic step(input logic valid, input fp_isa_pkg::fpu_req_t req,
		output logic accepted);
		@(negedge clk);
		in_valid = valid;
		in = req;
		out_ready = ($urandom_range(99) >= stall_pct);
		#1;
		if (!in_ready) begin
			check_value("held_count", 64'd3, 64'(expected_q.size()));
		end
		accepted = valid && in_ready;
		if (out_valid && out_ready) begin
			take_result();
		end
		if (accepted) begin
			expected_q.push_back(predict_response(req));
		end
	endtask

	task automatic issue(input fp_isa_pkg::fpu_req_t req);
		logic accepted;
		accepted = 1'b0;
		while (!accepted) begin
			step(1'b1, req, accepted);
		end
	endtask

	task automatic drain();
		logic accepted;
		while (expected_q.size() != 0) begin
			step(1'b0, '0, accepted);
		end
	endtask

	task automatic run_test(input string name, input int count, input int kind, input int stall);
		int start_errors;
		start_errors = errors;
		stall_pct = stall;
		for (int i = 0; i < count; i++) begin
			if (kind == 4) begin
				issue(random_req(int'($urandom_range(3))));
			end else begin
				issue(random_req(kind));
			end
		end
		drain();
		$display("test %s finished: %0d requests, %0d errors", name, count,
			errors - start_errors);
	endtask

	initial begin
		void'($urandom(16));
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in = '0;
		out_ready = 1'b1;
		errors = 0;
		checks = 0;
		cycles = 0;
		stall_pct = 0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		check_value("out_valid", 64'd0, 64'(out_valid));
		check_value("in_ready", 64'd1, 64'(in_ready));

		run_test("sign_injection", N_SIGN, 0, 0);
		run_test("fclass", N_CLASS, 1, 0);
		run_test("moves_conversions", N_MOVE, 2, 0);
		run_test("illegal", N_ILLEGAL, 3, 0);
		run_test("backpressure_order", N_MIXED, 4, 40);

		$display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/rv_fpu.sv ====
`default_nettype none

module rv_fpu (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	output logic in_ready,
	input wire fp_isa_pkg::fpu_req_t in,
	output logic out_valid,
	input wire logic out_ready,
	output fp_isa_pkg::fpu_resp_t out
);

	logic dec_valid;
	logic dec_ready;
	fp_isa_pkg::dec_t dec;

	logic ex_valid;
	logic ex_ready;
	fp_isa_pkg::exec_t ex;

	fp_decode decode_i (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in(in),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec(dec)
	);

	fp_execute execute_i (
		.clk(clk),
		.rst_n(rst_n),
		.dec_valid(dec_valid),
		.dec_ready(dec_ready),
		.dec(dec),
		.ex_valid(ex_valid),
		.ex_ready(ex_ready),
		.ex(ex)
	);

	fp_pack pack_i (
		.clk(clk),
		.rst_n(rst_n),
		.ex_valid(ex_valid),
		.ex_ready(ex_ready),
		.ex(ex),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out(out)
	);

endmodule

`default_nettype wire

// ==== logic/fp_pack.sv ====
`default_nettype none

module fp_pack (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic ex_valid,
	output logic ex_ready,
	input wire fp_isa_pkg::exec_t ex,
	output logic out_valid,
	input wire logic out_ready,
	output fp_isa_pkg::fpu_resp_t out
);

	logic signed [fp_format_pkg::I_EXP_LEN-1:0] biased;
	logic [fp_format_pkg::I_EXP_LEN-1:0] dn_shift;
	logic sign;
	logic [fp_format_pkg::D_EXP_LEN-1:0] e_field;
	logic [fp_format_pkg::I_SIG_LEN-1:0] sig;
	logic [fp_format_pkg::REG_LEN-1:0] fp_bits;
	fp_isa_pkg::fpu_resp_t out_next;

	always_comb begin
		biased = ex.res.exponent + $signed(fp_format_pkg::exp_bias(ex.dst_fmt));
		dn_shift = 14'd1 - biased;
		sign = ex.res.sign;
		e_field = biased[fp_format_pkg::D_EXP_LEN-1:0];
		sig = ex.res.significand;
		case (ex.res.tag)
			fp_format_pkg::FINITE: begin
				// too small for a normal, shift into subnormal form
				if (biased < 14'sd1) begin
					e_field = '0;
					sig = ex.res.significand >> dn_shift;
				end
			end
			fp_format_pkg::ZERO: begin
				e_field = '0;
				sig = '0;
			end
			fp_format_pkg::INFINITY: begin
				e_field = '1;
				sig = '0;
			end
			default: begin
				e_field = '1;
				// canonical nan after conversion
				if (ex.op == fp_isa_pkg::OP_CVT_FF) begin
					sign = 1'b0;
					sig = {2'b11, 51'b0};
				end
			end
		endcase

		case (ex.dst_fmt)
			fp_format_pkg::H: begin
				fp_bits = {48'b0, sign, e_field[fp_format_pkg::H_EXP_LEN-1:0],
					sig[51 -: fp_format_pkg::H_FRAC_LEN]};
			end
			fp_format_pkg::S: begin
				fp_bits = {32'b0, sign, e_field[fp_format_pkg::S_EXP_LEN-1:0],
					sig[51 -: fp_format_pkg::S_FRAC_LEN]};
			end
			default: begin
				fp_bits = {sign, e_field, sig[51 -: fp_format_pkg::D_FRAC_LEN]};
			end
		endcase

		out_next.sigill = 1'b0;
		out_next.rd = fp_bits;
		case (ex.op)
			fp_isa_pkg::OP_MV_X_F: begin
				case (ex.dst_fmt)
					fp_format_pkg::H: out_next.rd = {{48{ex.raw_bits[15]}}, ex.raw_bits[15:0]};
					fp_format_pkg::S: out_next.rd = {{32{ex.raw_bits[31]}}, ex.raw_bits[31:0]};
					default: out_next.rd = ex.raw_bits;
				endcase
			end
			fp_isa_pkg::OP_MV_F_X: begin
				case (ex.dst_fmt)
					fp_format_pkg::H: out_next.rd = {48'b0, ex.raw_bits[15:0]};
					fp_format_pkg::S: out_next.rd = {32'b0, ex.raw_bits[31:0]};
					default: out_next.rd = ex.raw_bits;
				endcase
			end
			fp_isa_pkg::OP_CLASS: out_next.rd = {54'b0, ex.raw_bits[9:0]};
			fp_isa_pkg::OP_ILLEGAL: begin
				out_next.sigill = 1'b1;
				out_next.rd = '0;
			end
			default: ;
		endcase
	end

	assign ex_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (ex_ready) begin
			out_valid <= ex_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid && ex_ready) begin
			out <= out_next;
		end
	end

	// decode turns every Q encoding into an illegal op
	assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid && ex.op != fp_isa_pkg::OP_ILLEGAL |-> ex.dst_fmt != fp_format_pkg::Q)
		else $error("legal op with Q format reached pack");

endmodule

`default_nettype wire

// ==== logic/fp_execute.sv ====
`default_nettype none

module fp_execute (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic dec_valid,
	output logic dec_ready,
	input wire fp_isa_pkg::dec_t dec,
	output logic ex_valid,
	input wire logic ex_ready,
	output fp_isa_pkg::exec_t ex
);

	fp_format_pkg::unpacked_t op_a;
	fp_format_pkg::unpacked_t op_b;
	logic signed [fp_format_pkg::I_EXP_LEN-1:0] min_exp;
	logic subnormal;
	logic [9:0] class_mask;
	fp_isa_pkg::exec_t ex_next;

	fp_unpack unpack_a (
		.fmt(dec.src_fmt),
		.value(dec.rs1),
		.result(op_a)
	);

	fp_unpack unpack_b (
		.fmt(dec.src_fmt),
		.value(dec.rs2),
		.result(op_b)
	);

	always_comb begin
		// below the normal range of the source format
		min_exp = 14'sd1 - $signed(fp_format_pkg::exp_bias(dec.src_fmt));
		subnormal = (op_a.exponent < min_exp);

		class_mask = '0;
		case (op_a.tag)
			fp_format_pkg::INFINITY: begin
				class_mask[op_a.sign ? 0 : 7] = 1'b1;
			end
			fp_format_pkg::ZERO: begin
				class_mask[op_a.sign ? 3 : 4] = 1'b1;
			end
			fp_format_pkg::NAN: begin
				class_mask[op_a.quiet ? 9 : 8] = 1'b1;
			end
			default: begin
				if (subnormal) begin
					class_mask[op_a.sign ? 2 : 5] = 1'b1;
				end else begin
					class_mask[op_a.sign ? 1 : 6] = 1'b1;
				end
			end
		endcase

		ex_next.op = dec.op;
		ex_next.dst_fmt = dec.dst_fmt;
		ex_next.res = op_a;
		ex_next.raw_bits = dec.rs1;
		case (dec.op)
			fp_isa_pkg::OP_SGNJ: ex_next.res.sign = op_b.sign;
			fp_isa_pkg::OP_SGNJN: ex_next.res.sign = !op_b.sign;
			fp_isa_pkg::OP_SGNJX: ex_next.res.sign = op_a.sign ^ op_b.sign;
			fp_isa_pkg::OP_CLASS: ex_next.raw_bits = {54'b0, class_mask};
			default: ;
		endcase
	end

	assign dec_ready = !ex_valid || ex_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else if (dec_ready) begin
			ex_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (dec_valid && dec_ready) begin
			ex <= ex_next;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid && !ex_ready |=> ex_valid && $stable(ex))
		else $error("ex changed while stalled");

endmodule

`default_nettype wire

// ==== logic/fp_decode.sv ====
`default_nettype none

module fp_decode (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic in_valid,
	output logic in_ready,
	input wire fp_isa_pkg::fpu_req_t in,
	output logic dec_valid,
	input wire logic dec_ready,
	output fp_isa_pkg::dec_t dec
);

	fp_format_pkg::fmt_e fmt;
	fp_format_pkg::fmt_e cvt_src;
	logic fmt_ok;
	logic widening;
	fp_isa_pkg::dec_t dec_next;

	always_comb begin
		fmt = fp_format_pkg::fmt_e'(in.funct7[1:0]);
		cvt_src = fp_format_pkg::fmt_e'(in.funct5[1:0]);
		fmt_ok = (fmt != fp_format_pkg::Q);
		widening = (fmt == fp_format_pkg::S && cvt_src == fp_format_pkg::H) ||
			(fmt == fp_format_pkg::D && cvt_src == fp_format_pkg::H) ||
			(fmt == fp_format_pkg::D && cvt_src == fp_format_pkg::S);

		dec_next.op = fp_isa_pkg::OP_ILLEGAL;
		dec_next.dst_fmt = fmt;
		dec_next.src_fmt = fmt;
		dec_next.rs1 = in.rs1;
		dec_next.rs2 = in.rs2;

		case (fp_isa_pkg::opcode_e'(in.opcode))
			fp_isa_pkg::OP_FP: begin
				case (in.funct7[6:2])
					5'b00100: begin
						if (fmt_ok) begin
							case (in.rm)
								3'b000: dec_next.op = fp_isa_pkg::OP_SGNJ;
								3'b001: dec_next.op = fp_isa_pkg::OP_SGNJN;
								3'b010: dec_next.op = fp_isa_pkg::OP_SGNJX;
								default: ;
							endcase
						end
					end
					// only the exact widening float to float converts
					5'b01000: begin
						if (in.funct5[4:2] == 3'b000 && widening) begin
							dec_next.op = fp_isa_pkg::OP_CVT_FF;
							dec_next.src_fmt = cvt_src;
						end
					end
					5'b11100: begin
						if (fmt_ok && {in.rm, in.funct5} == 8'b000_00000) begin
							dec_next.op = fp_isa_pkg::OP_MV_X_F;
						end else if (fmt_ok && {in.rm, in.funct5} == 8'b001_00000) begin
							dec_next.op = fp_isa_pkg::OP_CLASS;
						end
					end
					5'b11110: begin
						if (fmt_ok && {in.rm, in.funct5} == 8'b000_00000) begin
							dec_next.op = fp_isa_pkg::OP_MV_F_X;
						end
					end
					// arithmetic, compares, int conversions
					default: ;
				endcase
			end
			// fused multiply-add family and all other opcodes stay illegal
			default: ;
		endcase
	end

	assign in_ready = !dec_valid || dec_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (in_ready) begin
			dec_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			dec <= dec_next;
		end
	end

	// held item must not change before execute takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec))
		else $error("dec changed while stalled");

endmodule

`default_nettype wire

// ==== logic/fp_unpack.sv ====
`default_nettype none

module fp_unpack (
	input wire fp_format_pkg::fmt_e fmt,
	input wire logic [fp_format_pkg::REG_LEN-1:0] value,
	output fp_format_pkg::unpacked_t result
);

	logic sign;
	logic [fp_format_pkg::D_EXP_LEN-1:0] e_field;
	logic e_max;
	// fraction left-aligned to double width
	logic [fp_format_pkg::D_FRAC_LEN-1:0] frac;
	logic [fp_format_pkg::I_EXP_LEN-1:0] bias;
	logic [fp_format_pkg::I_SIG_LEN-1:0] sub_sig;
	logic [5:0] lz;

	always_comb begin
		bias = fp_format_pkg::exp_bias(fmt);
		case (fmt)
			fp_format_pkg::H: begin
				sign = value[15];
				e_field = 11'(value[14:10]);
				e_max = &value[14:10];
				frac = {value[fp_format_pkg::H_FRAC_LEN-1:0], 42'b0};
			end
			fp_format_pkg::S: begin
				sign = value[31];
				e_field = 11'(value[30:23]);
				e_max = &value[30:23];
				frac = {value[fp_format_pkg::S_FRAC_LEN-1:0], 29'b0};
			end
			default: begin
				sign = value[63];
				e_field = value[62:52];
				e_max = &value[62:52];
				frac = value[fp_format_pkg::D_FRAC_LEN-1:0];
			end
		endcase

		// subnormal normalization
		sub_sig = {1'b0, frac};
		lz = '0;
		for (int i = 0; i < fp_format_pkg::I_SIG_LEN; i++) begin
			if (sub_sig[i]) begin
				lz = 6'(fp_format_pkg::I_SIG_LEN - 1 - i);
			end
		end

		result.sign = sign;
		result.quiet = frac[fp_format_pkg::D_FRAC_LEN-1];
		result.exponent = '0;
		result.significand = {1'b1, frac};
		if (e_max) begin
			result.tag = (frac == '0) ? fp_format_pkg::INFINITY : fp_format_pkg::NAN;
		end else if (e_field == '0) begin
			if (frac == '0) begin
				result.tag = fp_format_pkg::ZERO;
				result.significand = '0;
			end else begin
				result.tag = fp_format_pkg::FINITE;
				result.exponent = 14'd1 - bias - 14'(lz);
				result.significand = sub_sig << lz;
			end
		end else begin
			result.tag = fp_format_pkg::FINITE;
			result.exponent = 14'(e_field) - bias;
		end
	end

endmodule

`default_nettype wire

// ==== logic/fp_isa_pkg.sv ====
`default_nettype none

package fp_isa_pkg;

	// major opcodes, instruction bits [6:2]
	typedef enum logic [4:0] {
		MADD = 5'b10000,
		MSUB = 5'b10001,
		NMSUB = 5'b10010,
		NMADD = 5'b10011,
		OP_FP = 5'b10100
	} opcode_e;

	typedef enum logic [2:0] {
		OP_SGNJ,
		OP_SGNJN,
		OP_SGNJX,
		OP_CVT_FF,
		OP_MV_X_F,
		OP_MV_F_X,
		OP_CLASS,
		OP_ILLEGAL
	} fp_op_e;

	typedef struct packed {
		logic [4:0] opcode;
		logic [6:0] funct7;
		logic [2:0] rm;
		logic [4:0] funct5;
		logic [fp_format_pkg::REG_LEN-1:0] rs1;
		logic [fp_format_pkg::REG_LEN-1:0] rs2;
		logic [fp_format_pkg::REG_LEN-1:0] rs3;
	} fpu_req_t;

	typedef struct packed {
		logic sigill;
		logic [fp_format_pkg::REG_LEN-1:0] rd;
	} fpu_resp_t;

	typedef struct packed {
		fp_op_e op;
		fp_format_pkg::fmt_e dst_fmt;
		fp_format_pkg::fmt_e src_fmt;
		logic [fp_format_pkg::REG_LEN-1:0] rs1;
		logic [fp_format_pkg::REG_LEN-1:0] rs2;
	} dec_t;

	typedef struct packed {
		fp_op_e op;
		fp_format_pkg::fmt_e dst_fmt;
		fp_format_pkg::unpacked_t res;
		// move operand or class mask
		logic [fp_format_pkg::REG_LEN-1:0] raw_bits;
	} exec_t;

endpackage

`default_nettype wire

// ==== logic/fp_format_pkg.sv ====
`default_nettype none

package fp_format_pkg;

	// encoding of the fmt field in funct7[1:0] and funct5[1:0]
	typedef enum logic [1:0] {
		S = 2'b00,
		D = 2'b01,
		H = 2'b10,
		Q = 2'b11
	} fmt_e;

	localparam int H_EXP_LEN = 5;
	localparam int H_FRAC_LEN = 10;
	localparam int S_EXP_LEN = 8;
	localparam int S_FRAC_LEN = 23;
	localparam int D_EXP_LEN = 11;
	localparam int D_FRAC_LEN = 52;

	localparam int REG_LEN = 64;

	// unbiased exponent, signed, covers the smallest double subnormal
	localparam int I_EXP_LEN = 14;
	localparam int I_SIG_LEN = 53;

	typedef enum logic [1:0] {
		FINITE,
		INFINITY,
		NAN,
		ZERO
	} tag_e;

	typedef struct packed {
		tag_e tag;
		logic sign;
		logic quiet;
		logic signed [I_EXP_LEN-1:0] exponent;
		// leading one on top, fraction left-aligned below it
		logic [I_SIG_LEN-1:0] significand;
	} unpacked_t;

	function automatic logic [I_EXP_LEN-1:0] exp_bias(fmt_e fmt);
		case (fmt)
			H: return I_EXP_LEN'((1 << (H_EXP_LEN - 1)) - 1);
			S: return I_EXP_LEN'((1 << (S_EXP_LEN - 1)) - 1);
			default: return I_EXP_LEN'((1 << (D_EXP_LEN - 1)) - 1);
		endcase
	endfunction

endpackage

`default_nettype wire
